// ==== include/alu_iq_config.svh ====
`ifndef ALU_IQ_CONFIG_SVH
`define ALU_IQ_CONFIG_SVH

// queue geometry
`define IQ_SIZE   4
`define IQ_AGE_W  3

// datapath widths
`define WORD_W    32
`define ROB_ID_W  5

// broadcast ports snooped by every entry
`define CDB_COUNT 2

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the issue queue testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -j 0 \
    --top-module tb_alu_iq -Mdir "$OBJ" -f sim.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ/Vtb_alu_iq" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
exit 0

// ==== sim.f ====
+incdir+include
source/alu_iq_pkg.sv
source/iq_entry.sv
source/iq_age_select.sv
source/alu_unit.sv
source/alu_iq.sv
tb/tb_alu_iq.sv

// ==== source/alu_iq.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "alu_iq_config.svh"

module alu_iq
    import alu_iq_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_i,
    input  logic                        flush_i,
    input  logic                        dispatch_valid_i,
    input  dispatch_info_t              dispatch_i,
    output logic                        iq_ready_o,
    input  cdb_info_t [`CDB_COUNT-1:0]  cdb_i,
    output logic                        result_valid_o,
    output alu_result_t                 result_o,
    input  logic                        result_ready_i
);

    localparam int CNT_W = $clog2(`IQ_SIZE + 1);

    logic [`IQ_SIZE-1:0]            entry_valid;
    logic [`IQ_SIZE-1:0]            entry_ready;
    dispatch_info_t [`IQ_SIZE-1:0]  entry_info;
    logic [`IQ_SIZE-1:0]            alloc_vec;
    logic [`IQ_SIZE-1:0]            grant_vec;
    logic [`IQ_SIZE-1:0]            issue_vec;
    logic [CNT_W-1:0]               free_cnt;
    logic                           alloc_found;
    logic                           dispatch_fire;

    // ----------------------------------------------------------------------
    // allocation
    always_comb begin
        free_cnt = '0;
        for (int i = 0; i < `IQ_SIZE; i++) begin
            free_cnt = free_cnt + CNT_W'(!entry_valid[i]);
        end
    end

    assign iq_ready_o    = (free_cnt != '0);
    assign dispatch_fire = dispatch_valid_i && iq_ready_o;

    // lowest empty slot takes the dispatch
    always_comb begin
        alloc_vec   = '0;
        alloc_found = 1'b0;
        for (int i = 0; i < `IQ_SIZE; i++) begin
            if (!entry_valid[i] && !alloc_found) begin
                alloc_found  = 1'b1;
                alloc_vec[i] = dispatch_fire;
            end
        end
    end

    // ----------------------------------------------------------------------
    // queue slots and picker
    for (genvar i = 0; i < `IQ_SIZE; i++) begin : gen_entry
        iq_entry entry_i (
            .clk        (clk),
            .rst_i      (rst_i),
            .flush_i    (flush_i),
            .alloc_i    (alloc_vec[i]),
            .issue_i    (issue_vec[i]),
            .dispatch_i (dispatch_i),
            .cdb_i      (cdb_i),
            .valid_o    (entry_valid[i]),
            .ready_o    (entry_ready[i]),
            .info_o     (entry_info[i])
        );
    end

    iq_age_select age_select_i (
        .clk     (clk),
        .rst_i   (rst_i),
        .flush_i (flush_i),
        .alloc_i (alloc_vec),
        .ready_i (entry_ready),
        .grant_o (grant_vec)
    );

    // ----------------------------------------------------------------------
    // issue stage
    logic           res_adv;
    logic           iss_adv;
    logic           iss_valid_q;
    dispatch_info_t iss_info_q;
    dispatch_info_t sel_info;

    assign res_adv   = !result_valid_o || result_ready_i;
    assign iss_adv   = !iss_valid_q || res_adv;
    // grant only leaves the queue when the issue register takes it
    assign issue_vec = grant_vec & {`IQ_SIZE{iss_adv}};

    always_comb begin
        sel_info = '0;
        for (int i = 0; i < `IQ_SIZE; i++) begin
            if (grant_vec[i]) begin
                sel_info = entry_info[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            iss_valid_q <= 1'b0;
        end else if (iss_adv) begin
            iss_valid_q <= |grant_vec;
        end
    end

    always_ff @(posedge clk) begin
        if (iss_adv) begin
            iss_info_q <= sel_info;
        end
    end

    // ----------------------------------------------------------------------
    // execute and result register
    word_t       alu_res;
    alu_result_t res_q;

    alu_unit alu_i (
        .op_i  (iss_info_q.op),
        .a_i   (iss_info_q.src[0].value),
        .b_i   (iss_info_q.src[1].value),
        .res_o (alu_res)
    );

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            result_valid_o <= 1'b0;
        end else if (res_adv) begin
            result_valid_o <= iss_valid_q;
        end
    end

    always_ff @(posedge clk) begin
        if (res_adv) begin
            res_q.data <= alu_res;
            res_q.dest <= iss_info_q.dest;
        end
    end

    assign result_o = res_q;

    // ----------------------------------------------------------------------
    // interface checks
    a_dispatch_when_ready : assert property (
        @(posedge clk) disable iff (rst_i)
        dispatch_valid_i |-> iq_ready_o
    );

    a_result_hold : assert property (
        @(posedge clk) disable iff (rst_i || flush_i)
        (result_valid_o && !result_ready_i) |=> (result_valid_o && $stable(result_o))
    );

endmodule

`default_nettype wire

// ==== source/alu_iq_pkg.sv ====
`default_nettype none

`include "alu_iq_config.svh"

package alu_iq_pkg;

    typedef logic [`WORD_W-1:0]   word_t;
    typedef logic [`ROB_ID_W-1:0] rob_id_t;

    // ----------------------------------------------------------------------
    // supported integer operations
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_t;

    // ----------------------------------------------------------------------
    // one source operand, value or producer tag
    typedef struct packed {
        word_t   value;
        rob_id_t tag;
        logic    valid;
    } iq_operand_t;

    // src[0] feeds alu a, src[1] feeds alu b
    typedef struct packed {
        alu_op_t           op;
        rob_id_t           dest;
        iq_operand_t [1:0] src;
    } dispatch_info_t;

    typedef struct packed {
        word_t   data;
        rob_id_t tag;
        logic    valid;
    } cdb_info_t;

    // toward writeback FIFO
    typedef struct packed {
        word_t   data;
        rob_id_t dest;
    } alu_result_t;

endpackage

`default_nettype wire

// ==== source/alu_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu_unit
    import alu_iq_pkg::*;
(
    input  alu_op_t op_i,
    input  word_t   a_i,
    input  word_t   b_i,
    output word_t   res_o
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b_i[4:0];
    assign lt_signed   = $signed(a_i) < $signed(b_i);
    assign lt_unsigned = a_i < b_i;

    always_comb begin
        case (op_i)
            ALU_ADD: begin
                res_o = a_i + b_i;
            end
            ALU_SUB: begin
                res_o = a_i - b_i;
            end
            ALU_AND: begin
                res_o = a_i & b_i;
            end
            ALU_OR: begin
                res_o = a_i | b_i;
            end
            ALU_XOR: begin
                res_o = a_i ^ b_i;
            end
            // shifts only look at the low five bits of b
            ALU_SLL: begin
                res_o = a_i << shamt;
            end
            ALU_SRL: begin
                res_o = a_i >> shamt;
            end
            ALU_SRA: begin
                res_o = word_t'($signed(a_i) >>> shamt);
            end
            // compares give 0 or 1
            ALU_SLT: begin
                res_o = word_t'(lt_signed);
            end
            ALU_SLTU: begin
                res_o = word_t'(lt_unsigned);
            end
            default: begin
                res_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== source/iq_age_select.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "alu_iq_config.svh"

module iq_age_select (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic                   flush_i,
    input  logic [`IQ_SIZE-1:0]    alloc_i,
    input  logic [`IQ_SIZE-1:0]    ready_i,
    output logic [`IQ_SIZE-1:0]    grant_o
);

    localparam int IDX_W = (`IQ_SIZE > 1) ? $clog2(`IQ_SIZE) : 1;

    logic [`IQ_SIZE-1:0][`IQ_AGE_W-1:0] age_q;
    logic                               sel_found;
    logic [`IQ_AGE_W-1:0]               sel_age;
    logic [IDX_W-1:0]                   sel_idx;

    // ----------------------------------------------------------------------
    // saturating age per slot
    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            age_q <= '0;
        end else begin
            for (int i = 0; i < `IQ_SIZE; i++) begin
                if (alloc_i[i]) begin
                    age_q[i] <= '0;
                end else if (age_q[i] != '1) begin
                    age_q[i] <= age_q[i] + 1'b1;
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // oldest ready wins, strict compare keeps ties on the lower index
    always_comb begin
        sel_found = 1'b0;
        sel_age   = '0;
        sel_idx   = '0;
        for (int i = 0; i < `IQ_SIZE; i++) begin
            if (ready_i[i] && (!sel_found || (age_q[i] > sel_age))) begin
                sel_found = 1'b1;
                sel_age   = age_q[i];
                sel_idx   = IDX_W'(i);
            end
        end
        grant_o = '0;
        if (sel_found) begin
            grant_o[sel_idx] = 1'b1;
        end
    end

    a_grant_legal : assert property (
        @(posedge clk) disable iff (rst_i)
        $onehot0(grant_o) && ((grant_o & ~ready_i) == '0)
    );

endmodule

`default_nettype wire

// ==== source/iq_entry.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "alu_iq_config.svh"

module iq_entry
    import alu_iq_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst_i,
    input  logic                            flush_i,
    input  logic                            alloc_i,
    input  logic                            issue_i,
    input  dispatch_info_t                  dispatch_i,
    input  cdb_info_t [`CDB_COUNT-1:0]      cdb_i,
    output logic                            valid_o,
    output logic                            ready_o,
    output dispatch_info_t                  info_o
);

    logic           valid_q;
    dispatch_info_t info_q;
    dispatch_info_t info_d;

    // ----------------------------------------------------------------------
    // occupancy
    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            valid_q <= 1'b0;
        end else if (alloc_i) begin
            valid_q <= 1'b1;
        end else if (issue_i) begin
            valid_q <= 1'b0;
        end
    end

    // ----------------------------------------------------------------------
    // operand wakeup
    // new dispatch also snoops the bus in its own alloc cycle
    always_comb begin
        info_d = alloc_i ? dispatch_i : info_q;
        for (int s = 0; s < 2; s++) begin
            for (int c = 0; c < `CDB_COUNT; c++) begin
                if (!info_d.src[s].valid && cdb_i[c].valid &&
                    (cdb_i[c].tag == info_d.src[s].tag)) begin
                    info_d.src[s].value = cdb_i[c].data;
                    info_d.src[s].valid = 1'b1;
                end
            end
        end
    end

    // payload only moves while the slot is in use
    always_ff @(posedge clk) begin
        if (alloc_i || valid_q) begin
            info_q <= info_d;
        end
    end

    assign valid_o = valid_q;
    assign ready_o = valid_q && info_q.src[0].valid && info_q.src[1].valid;
    assign info_o  = info_q;

    // ----------------------------------------------------------------------
    // allocation targets empty slots, the picker only grants filled ones
    a_no_alloc_on_issue : assert property (
        @(posedge clk) disable iff (rst_i)
        !(alloc_i && issue_i)
    );

endmodule

`default_nettype wire

// ==== tb/tb_alu_iq.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "alu_iq_config.svh"

module tb_alu_iq
    import alu_iq_pkg::*;
();

    // generous margin over the summed test lengths
    localparam int          MAX_CYCLES = 2000;
    localparam logic [31:0] SEED       = 32'ha23f;

    logic                       clk;
    logic                       rst_i;
    logic                       flush_i;
    logic                       dispatch_valid_i;
    dispatch_info_t             dispatch_i;
    logic                       iq_ready_o;
    cdb_info_t [`CDB_COUNT-1:0] cdb_i;
    logic                       result_valid_o;
    alu_result_t                result_o;
    logic                       result_ready_i = 1'b1;

    logic [31:0]    lcg_state;
    logic [31:0]    bp_state = SEED;
    logic           bp_enable;
    int             err_cnt;
    int             test_cnt;
    int             fail_cnt;
    alu_result_t    got_q[$];
    alu_result_t    exp_q[$];
    dispatch_info_t burst_q[$];

    always #2 clk = ~clk;

    alu_iq alu_iq_i (
        .clk              (clk),
        .rst_i            (rst_i),
        .flush_i          (flush_i),
        .dispatch_valid_i (dispatch_valid_i),
        .dispatch_i       (dispatch_i),
        .iq_ready_o       (iq_ready_o),
        .cdb_i            (cdb_i),
        .result_valid_o   (result_valid_o),
        .result_o         (result_o),
        .result_ready_i   (result_ready_i)
    );

    // ----------------------------------------------------------------------
    // random numbers, result monitor, back-pressure
    function automatic logic [31:0] lcg_step(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function logic [31:0] next_rand();
        lcg_state = lcg_step(lcg_state);
        return lcg_state;
    endfunction

    always @(posedge clk) begin
        if (!rst_i && result_valid_o && result_ready_i) begin
            got_q.push_back(result_o);
        end
    end

    // ready never stays low two cycles in a row
    always @(posedge clk) begin
        if (bp_enable && result_ready_i) begin
            bp_state       <= lcg_step(bp_state);
            result_ready_i <= bp_state[16];
        end else begin
            result_ready_i <= 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // reference model of the alu op rules
    function automatic word_t alu_model(alu_op_t op, word_t a, word_t b);
        word_t r;
        word_t ones;
        int    sh;
        ones = '1;
        sh   = int'(b[4:0]);
        case (op)
            ALU_ADD:  r = a + b;
            ALU_SUB:  r = a + ~b + 1'b1;
            ALU_AND:  r = a & b;
            ALU_OR:   r = a | b;
            ALU_XOR:  r = a ^ b;
            ALU_SLL:  r = a << sh;
            ALU_SRL:  r = a >> sh;
            ALU_SRA: begin
                r = a >> sh;
                if (a[`WORD_W-1]) begin
                    r = r | ~(ones >> sh);
                end
            end
            // differing signs decide a signed compare on their own
            ALU_SLT: begin
                if (a[`WORD_W-1] != b[`WORD_W-1]) begin
                    r = word_t'(a[`WORD_W-1]);
                end else begin
                    r = word_t'(a < b);
                end
            end
            ALU_SLTU: r = word_t'(a < b);
            default:  r = '0;
        endcase
        return r;
    endfunction

    function automatic iq_operand_t ready_operand(word_t v);
        iq_operand_t o;
        o.value = v;
        o.tag   = '0;
        o.valid = 1'b1;
        return o;
    endfunction

    function automatic iq_operand_t pending_operand(rob_id_t t);
        iq_operand_t o;
        o.value = '0;
        o.tag   = t;
        o.valid = 1'b0;
        return o;
    endfunction

    function automatic dispatch_info_t build_dispatch(alu_op_t op, rob_id_t dest,
                                                      iq_operand_t s0, iq_operand_t s1);
        dispatch_info_t d;
        d.op     = op;
        d.dest   = dest;
        d.src[0] = s0;
        d.src[1] = s1;
        return d;
    endfunction

    function automatic alu_result_t expected_result(alu_op_t op, rob_id_t dest,
                                                    word_t a, word_t b);
        alu_result_t r;
        r.data = alu_model(op, a, b);
        r.dest = dest;
        return r;
    endfunction

    // ----------------------------------------------------------------------
    // compare tasks
    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_rob_id(string name, rob_id_t got, rob_id_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    // ----------------------------------------------------------------------
    // drivers
    // strobe is low at the negedge, so the next edge cannot fill the queue
    task automatic send_one(dispatch_info_t d);
        @(negedge clk);
        while (!iq_ready_o) begin
            @(negedge clk);
        end
        @(posedge clk);
        dispatch_valid_i <= 1'b1;
        dispatch_i       <= d;
        @(posedge clk);
        dispatch_valid_i <= 1'b0;
    endtask

    // back-to-back dispatches into a queue that has room for all of them
    task automatic send_burst();
        @(negedge clk);
        while (burst_q.size() != 0) begin
            @(posedge clk);
            dispatch_valid_i <= 1'b1;
            dispatch_i       <= burst_q.pop_front();
        end
        @(posedge clk);
        dispatch_valid_i <= 1'b0;
    endtask

    task automatic broadcast(int port, rob_id_t tag, word_t data);
        cdb_info_t b;
        b.data  = data;
        b.tag   = tag;
        b.valid = 1'b1;
        @(posedge clk);
        cdb_i[port] <= b;
        @(posedge clk);
        cdb_i[port] <= '0;
    endtask

    task automatic broadcast_pair(rob_id_t tag0, word_t data0, rob_id_t tag1, word_t data1);
        cdb_info_t b0;
        cdb_info_t b1;
        b0.data  = data0;
        b0.tag   = tag0;
        b0.valid = 1'b1;
        b1.data  = data1;
        b1.tag   = tag1;
        b1.valid = 1'b1;
        @(posedge clk);
        cdb_i[0] <= b0;
        cdb_i[1] <= b1;
        @(posedge clk);
        cdb_i <= '0;
    endtask

    task automatic expect_no_result(int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_bit("result_valid_o", result_valid_o, 1'b0);
        end
    endtask

    task automatic drain_and_compare();
        alu_result_t got;
        alu_result_t exp;
        while (got_q.size() < exp_q.size()) begin
            @(posedge clk);
        end
        // extra results would show up within a few cycles
        repeat (8) @(posedge clk);
        if (got_q.size() != exp_q.size()) begin
            $display("error at %0t: received %0d results but expected %0d",
                     $time, got_q.size(), exp_q.size());
            err_cnt++;
        end
        while (got_q.size() != 0 && exp_q.size() != 0) begin
            got = got_q.pop_front();
            exp = exp_q.pop_front();
            check_word("result_o.data", got.data, exp.data);
            check_rob_id("result_o.dest", got.dest, exp.dest);
        end
        got_q.delete();
        exp_q.delete();
    endtask

    task automatic finish_test(string name, int errs_before);
        test_cnt++;
        if (err_cnt == errs_before) begin
            $display("test %s: PASS", name);
        end else begin
            fail_cnt++;
            $display("test %s: FAIL with %0d errors", name, err_cnt - errs_before);
        end
    endtask

    // ----------------------------------------------------------------------
    // tests
    task automatic test_all_ops();
        int             errs;
        word_t          a;
        word_t          b;
        dispatch_info_t d;
        errs = err_cnt;
        for (int i = 0; i < 10; i++) begin
            a = next_rand();
            b = next_rand();
            d = build_dispatch(alu_op_t'(4'(i)), rob_id_t'(i), ready_operand(a),
                               ready_operand(b));
            exp_q.push_back(expected_result(d.op, d.dest, a, b));
            send_one(d);
        end
        drain_and_compare();
        finish_test("all_ops", errs);
    endtask

    task automatic test_wakeup();
        int    errs;
        word_t a;
        word_t b;
        errs = err_cnt;
        a = next_rand();
        b = next_rand();
        exp_q.push_back(expected_result(ALU_SUB, 5'd17, a, b));
        send_one(build_dispatch(ALU_SUB, 5'd17, pending_operand(5'd20),
                                pending_operand(5'd21)));
        expect_no_result(4);
        // unrelated tag must not wake anything
        broadcast(0, 5'd22, next_rand());
        broadcast(1, 5'd21, b);
        expect_no_result(4);
        broadcast(0, 5'd20, a);
        drain_and_compare();
        finish_test("wakeup", errs);
    endtask

    task automatic test_age_order();
        int      errs;
        word_t   x;
        word_t   a;
        word_t   b;
        alu_op_t op;
        errs = err_cnt;
        // ready leader leaves slot 0 so the second waiter lands below the first
        a = next_rand();
        b = next_rand();
        burst_q.push_back(build_dispatch(ALU_ADD, 5'd5, ready_operand(a), ready_operand(b)));
        exp_q.push_back(expected_result(ALU_ADD, 5'd5, a, b));
        x = next_rand();
        for (int i = 0; i < `IQ_SIZE; i++) begin
            b  = next_rand();
            op = alu_op_t'(4'(i * 2));
            burst_q.push_back(build_dispatch(op, rob_id_t'(i + 1), pending_operand(5'd9),
                                             ready_operand(b)));
            exp_q.push_back(expected_result(op, rob_id_t'(i + 1), x, b));
        end
        send_burst();
        broadcast(1, 5'd9, x);
        drain_and_compare();
        finish_test("age_order", errs);
    endtask

    task automatic test_full();
        int          errs;
        word_t       a[`IQ_SIZE];
        alu_result_t r[`IQ_SIZE];
        word_t       b;
        errs = err_cnt;
        for (int i = 0; i < `IQ_SIZE; i++) begin
            a[i] = next_rand();
            b    = next_rand();
            burst_q.push_back(build_dispatch(ALU_OR, rob_id_t'(8 + i),
                                             pending_operand(rob_id_t'(10 + i)),
                                             ready_operand(b)));
            r[i] = expected_result(ALU_OR, rob_id_t'(8 + i), a[i], b);
        end
        send_burst();
        @(negedge clk);
        check_bit("iq_ready_o", iq_ready_o, 1'b0);
        broadcast(0, 5'd12, a[2]);
        // woken entry issues one edge after the capture
        @(negedge clk);
        check_bit("iq_ready_o", iq_ready_o, 1'b0);
        @(negedge clk);
        check_bit("iq_ready_o", iq_ready_o, 1'b1);
        broadcast_pair(5'd10, a[0], 5'd11, a[1]);
        broadcast(1, 5'd13, a[3]);
        exp_q.push_back(r[2]);
        exp_q.push_back(r[0]);
        exp_q.push_back(r[1]);
        exp_q.push_back(r[3]);
        drain_and_compare();
        finish_test("full", errs);
    endtask

    task automatic test_backpressure();
        int             errs;
        word_t          a;
        word_t          b;
        dispatch_info_t d;
        errs = err_cnt;
        @(posedge clk);
        bp_enable <= 1'b1;
        // back-to-back bursts so the issue register has to hold as well
        for (int r = 0; r < 2; r++) begin
            for (int i = 0; i < `IQ_SIZE; i++) begin
                a = next_rand();
                b = next_rand();
                d = build_dispatch(alu_op_t'(4'(next_rand() % 32'd10)),
                                   rob_id_t'(16 + r * `IQ_SIZE + i),
                                   ready_operand(a), ready_operand(b));
                exp_q.push_back(expected_result(d.op, d.dest, a, b));
                burst_q.push_back(d);
            end
            send_burst();
            drain_and_compare();
        end
        @(posedge clk);
        bp_enable <= 1'b0;
        finish_test("backpressure", errs);
    endtask

    task automatic test_flush();
        int    errs;
        word_t a;
        word_t b;
        errs = err_cnt;
        for (int i = 0; i < `IQ_SIZE; i++) begin
            burst_q.push_back(build_dispatch(ALU_XOR, rob_id_t'(24 + i),
                                             pending_operand(rob_id_t'(28 + i)),
                                             ready_operand(next_rand())));
        end
        send_burst();
        @(negedge clk);
        check_bit("iq_ready_o", iq_ready_o, 1'b0);
        @(posedge clk);
        flush_i <= 1'b1;
        @(posedge clk);
        flush_i <= 1'b0;
        @(negedge clk);
        check_bit("iq_ready_o", iq_ready_o, 1'b1);
        // discarded entries would wake on these tags
        broadcast_pair(5'd28, next_rand(), 5'd29, next_rand());
        expect_no_result(6);
        a = next_rand();
        b = next_rand();
        exp_q.push_back(expected_result(ALU_SLT, 5'd6, a, b));
        send_one(build_dispatch(ALU_SLT, 5'd6, ready_operand(a), ready_operand(b)));
        drain_and_compare();
        finish_test("flush", errs);
    endtask

    // ----------------------------------------------------------------------
    // main sequence and watchdog
    initial begin
        clk              = 1'b0;
        rst_i            = 1'b1;
        flush_i          = 1'b0;
        dispatch_valid_i = 1'b0;
        dispatch_i       = '0;
        cdb_i            = '0;
        bp_enable        = 1'b0;
        lcg_state        = SEED;
        err_cnt          = 0;
        test_cnt         = 0;
        fail_cnt         = 0;
        repeat (2) @(posedge clk);
        rst_i <= 1'b0;

        test_all_ops();
        test_wakeup();
        test_age_order();
        test_full();
        test_backpressure();
        test_flush();

        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 test_cnt, test_cnt - fail_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0 && fail_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin : watchdog
        int cycle_cnt;
        cycle_cnt = 0;
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, the DUT stopped producing results", cycle_cnt);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire
